//--- include/glay_defines.svh
/*
 * Global widths, depths and timing constants for the vertex subsystem.
 * Include this header in the package and in every RTL module that
 * sizes a vector or a counter from these values.
 */

`ifndef GLAY_DEFINES_SVH
`define GLAY_DEFINES_SVH

// Memory word address width
`define GLAY_ADDR_W 16

// Vertex value width
`define GLAY_DATA_W 32

// Entries per FIFO
`define GLAY_FIFO_DEPTH 8

// Cycles of reset-busy after FIFO reset falls
`define GLAY_RST_BUSY_CYCLES 4

`endif

//--- hw/glay_pkg.sv
/*
 * Shared types for the vertex subsystem.
 * Holds the job descriptor, the memory request and response entries,
 * and the status bundle that every FIFO reports.
 * Modules refer to these types by scoped name.
 */

`include "glay_defines.svh"

package glay_pkg;

    // -------------------------------------------------------------------------
    // Host job descriptor
    // -------------------------------------------------------------------------
    typedef struct packed {
        logic [`GLAY_ADDR_W-1:0] vertex_base;
        logic [`GLAY_ADDR_W-1:0] result_base;
        // Zero means no job
        logic [`GLAY_ADDR_W-1:0] vertex_count;
    } descriptor_t;

    // -------------------------------------------------------------------------
    // Memory port request and read response
    // -------------------------------------------------------------------------
    typedef struct packed {
        logic [`GLAY_ADDR_W-1:0] addr;
        // Write value, or the vertex index on a read
        logic [`GLAY_DATA_W-1:0] wdata;
        logic                    we;
    } cache_req_t;

    typedef struct packed {
        logic [`GLAY_DATA_W-1:0] rdata;
        // Vertex index of the read
        logic [`GLAY_ADDR_W-1:0] index;
    } cache_resp_t;

    // FIFO status seen by producers and consumers
    typedef struct packed {
        logic full;
        // One slot or less left
        logic almost_full;
        logic empty;
        logic rst_busy;
    } fifo_state_t;

endpackage

//--- hw/glay_sync_fifo.sv
/*
 * Single-clock FIFO with a show-ahead head and a reset-busy window.
 * The payload type is set per instance. Push and pop are ignored while
 * the FIFO is full, empty or still busy after reset.
 */

`include "glay_defines.svh"

module glay_sync_fifo #(
    parameter type payload_t = logic
) (
    input  logic                  ap_clk,
    input  logic                  srst,
    input  logic                  push,
    input  payload_t              din,
    input  logic                  pop,
    output payload_t              dout,
    output glay_pkg::fifo_state_t state
);

    localparam int DEPTH  = `GLAY_FIFO_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int BUSY_W = $clog2(`GLAY_RST_BUSY_CYCLES + 1);

    payload_t            mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [BUSY_W-1:0]   busy_cnt;
    logic                busy;
    logic                push_ok;
    logic                pop_ok;

    // -------------------------------------------------------------------------
    // Reset-busy window
    // -------------------------------------------------------------------------
    // Loaded during reset, counts down once reset falls
    always_ff @(posedge ap_clk) begin
        if (srst) begin
            busy_cnt <= BUSY_W'(`GLAY_RST_BUSY_CYCLES);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign busy = (busy_cnt != '0);

    // Qualified strobes
    assign push_ok = push & ~state.full & ~busy;
    assign pop_ok  = pop & ~state.empty & ~busy;

    // -------------------------------------------------------------------------
    // Pointers and occupancy
    // -------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop keeps the count
            if (push_ok && !pop_ok) begin
                count <= count + 1'b1;
            end else if (pop_ok && !push_ok) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // Head is visible before the pop
    assign dout = mem[rd_ptr];

    assign state.full        = (count == CNT_W'(DEPTH));
    assign state.almost_full = (count >= CNT_W'(DEPTH - 1));
    assign state.empty       = (count == '0);
    assign state.rst_busy    = busy;

endmodule

//--- hw/glay_kernel_setup.sv
/*
 * Kernel setup stage.
 * Registers the reset and the host descriptor, waits for both FIFOs to
 * leave reset-busy, then streams one vertex read per index into its own
 * request FIFO. The active job is published to the rest of the design
 * and cleared when the apply stage reports done.
 */

`include "glay_defines.svh"

module glay_kernel_setup (
    input  logic                  ap_clk,
    input  logic                  setup_areset,
    input  logic                  desc_valid,
    input  glay_pkg::descriptor_t desc,
    input  logic                  req_pop,
    output glay_pkg::cache_req_t  req_head,
    output glay_pkg::fifo_state_t req_state,
    output glay_pkg::descriptor_t job,
    input  glay_pkg::fifo_state_t resp_state,
    input  logic                  done
);

    logic                    rst_q;
    logic                    desc_valid_q;
    glay_pkg::descriptor_t   desc_q;
    glay_pkg::descriptor_t   job_q;
    logic [`GLAY_ADDR_W-1:0] issue_idx;
    logic                    job_active;
    logic                    fifo_busy;
    logic                    accept;
    logic                    more_reads;
    logic                    req_push;
    glay_pkg::cache_req_t    req_din;

    // -------------------------------------------------------------------------
    // Reset and descriptor registers
    // -------------------------------------------------------------------------
    // Local reset copy, also drives the request FIFO
    always_ff @(posedge ap_clk) begin
        rst_q <= setup_areset;
    end

    always_ff @(posedge ap_clk) begin
        if (rst_q) begin
            desc_valid_q <= 1'b0;
        end else begin
            desc_valid_q <= desc_valid;
        end
    end

    // Descriptor payload
    always_ff @(posedge ap_clk) begin
        desc_q <= desc;
    end

    // -------------------------------------------------------------------------
    // Job acceptance
    // -------------------------------------------------------------------------
    assign job_active = (job_q.vertex_count != '0);
    assign fifo_busy  = rst_q | req_state.rst_busy | resp_state.rst_busy;

    // Drop strobes during a job, during reset-busy, or with no vertices
    assign accept = desc_valid_q & ~job_active & ~fifo_busy &
                    (desc_q.vertex_count != '0);

    always_ff @(posedge ap_clk) begin
        if (rst_q) begin
            job_q     <= '0;
            issue_idx <= '0;
        end else if (accept) begin
            job_q     <= desc_q;
            issue_idx <= '0;
        end else begin
            if (done) begin
                job_q <= '0;
            end
            if (req_push) begin
                issue_idx <= issue_idx + 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Read request stream
    // -------------------------------------------------------------------------
    assign more_reads = job_active & (issue_idx < job_q.vertex_count);

    // Stall on a full FIFO so that no request is lost
    assign req_push = more_reads & ~req_state.full & ~req_state.rst_busy;

    always_comb begin
        req_din.addr  = job_q.vertex_base + issue_idx;
        // Vertex index rides in the unused write data of a read
        req_din.wdata = {{(`GLAY_DATA_W - `GLAY_ADDR_W){1'b0}}, issue_idx};
        req_din.we    = 1'b0;
    end

    assign job = job_q;

    glay_sync_fifo #(
        .payload_t(glay_pkg::cache_req_t)
    ) req_fifo_i (
        .ap_clk(ap_clk),
        .srst  (rst_q),
        .push  (req_push),
        .din   (req_din),
        .pop   (req_pop),
        .dout  (req_head),
        .state (req_state)
    );

endmodule

//--- hw/glay_vertex_apply.sv
/*
 * Vertex apply stage.
 * Takes one read response at a time, adds one to the vertex level and
 * holds the write to the result array until the arbiter grants it.
 * After the job's last granted write, done pulses for one cycle.
 */

`include "glay_defines.svh"

module glay_vertex_apply (
    input  logic                  ap_clk,
    input  logic                  setup_areset,
    input  glay_pkg::descriptor_t job,
    input  glay_pkg::cache_resp_t resp_head,
    input  glay_pkg::fifo_state_t resp_state,
    output logic                  resp_pop,
    output glay_pkg::cache_req_t  wr_req,
    output logic                  wr_pending,
    input  logic                  wr_grant,
    output logic                  done
);

    glay_pkg::cache_req_t    wr_req_q;
    logic                    wr_pending_q;
    logic [`GLAY_ADDR_W-1:0] wr_count;
    logic                    done_q;
    logic                    last_write;

    // Pop only with no write outstanding
    assign resp_pop = ~wr_pending_q & ~resp_state.empty & ~resp_state.rst_busy;

    // Next level is old level plus one
    always_ff @(posedge ap_clk) begin
        if (resp_pop) begin
            wr_req_q.addr  <= job.result_base + resp_head.index;
            wr_req_q.wdata <= resp_head.rdata + 1'b1;
            wr_req_q.we    <= 1'b1;
        end
    end

    // -------------------------------------------------------------------------
    // Write hold and completion count
    // -------------------------------------------------------------------------
    assign last_write = ((wr_count + 1'b1) == job.vertex_count);

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_pending_q <= 1'b0;
            wr_count     <= '0;
            done_q       <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (resp_pop) begin
                wr_pending_q <= 1'b1;
            end else if (wr_grant) begin
                wr_pending_q <= 1'b0;
                // Count restarts for the next job
                if (last_write) begin
                    wr_count <= '0;
                    done_q   <= 1'b1;
                end else begin
                    wr_count <= wr_count + 1'b1;
                end
            end
        end
    end

    assign wr_req     = wr_req_q;
    assign wr_pending = wr_pending_q;
    assign done       = done_q;

endmodule

//--- hw/glay_cache_arbiter.sv
/*
 * Round-robin arbiter for the shared memory port.
 * Chooses between the head of the read request FIFO and the pending
 * write of the apply stage, at most one per cycle. Reads are only
 * granted with room for their data, which returns one cycle later and
 * is pushed into the response FIFO with its vertex index.
 */

`include "glay_defines.svh"

module glay_cache_arbiter (
    input  logic                     ap_clk,
    input  logic                     setup_areset,
    input  glay_pkg::cache_req_t     req_head,
    input  glay_pkg::fifo_state_t    req_state,
    output logic                     req_pop,
    input  glay_pkg::cache_req_t     wr_req,
    input  logic                     wr_pending,
    output logic                     wr_grant,
    input  glay_pkg::fifo_state_t    resp_state,
    output logic                     resp_push,
    output glay_pkg::cache_resp_t    resp_din,
    output glay_pkg::cache_req_t     mem_req,
    output logic                     mem_valid,
    input  logic                     mem_rvalid,
    input  logic [`GLAY_DATA_W-1:0]  mem_rdata
);

    logic                    last_wr;
    logic                    rd_inflight;
    logic [`GLAY_ADDR_W-1:0] rd_idx_q;
    logic                    rd_credit;
    logic                    rd_ok;
    logic                    grant_rd;
    logic                    grant_wr;

    // -------------------------------------------------------------------------
    // Read credit
    // -------------------------------------------------------------------------
    // One outstanding read needs a second free slot
    assign rd_credit = ~resp_state.rst_busy &
                       (rd_inflight ? ~resp_state.almost_full : ~resp_state.full);

    assign rd_ok = ~req_state.empty & ~req_state.rst_busy & rd_credit;

    // Round-robin on the last winner
    assign grant_rd = rd_ok & (~wr_pending | last_wr);
    assign grant_wr = wr_pending & (~rd_ok | ~last_wr);

    assign req_pop  = grant_rd;
    assign wr_grant = grant_wr;

    // Memory port strobe for the winner
    assign mem_valid = grant_rd | grant_wr;
    assign mem_req   = grant_wr ? wr_req : req_head;

    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            last_wr     <= 1'b0;
            rd_inflight <= 1'b0;
        end else begin
            rd_inflight <= grant_rd;
            if (grant_rd) begin
                last_wr <= 1'b0;
            end else if (grant_wr) begin
                last_wr <= 1'b1;
            end
        end
    end

    // -------------------------------------------------------------------------
    // Response tagging
    // -------------------------------------------------------------------------
    // Index comes from the read's write data field
    always_ff @(posedge ap_clk) begin
        if (grant_rd) begin
            rd_idx_q <= req_head.wdata[`GLAY_ADDR_W-1:0];
        end
    end

    assign resp_push      = mem_rvalid;
    assign resp_din.rdata = mem_rdata;
    assign resp_din.index = rd_idx_q;

endmodule

//--- hw/glay_top.sv
/*
 * Top level of the vertex subsystem.
 * Connects kernel setup, vertex apply, the memory arbiter and the
 * response FIFO. The memory behind mem_req and mem_rdata lives outside
 * this block and answers each read one cycle after its strobe.
 */

`include "glay_defines.svh"

module glay_top (
    input  logic                    ap_clk,
    input  logic                    setup_areset,
    input  logic                    desc_valid,
    input  glay_pkg::descriptor_t   desc,
    output glay_pkg::cache_req_t    mem_req,
    output logic                    mem_valid,
    input  logic                    mem_rvalid,
    input  logic [`GLAY_DATA_W-1:0] mem_rdata,
    output logic                    done
);

    // Request path
    logic                  req_pop;
    glay_pkg::cache_req_t  req_head;
    glay_pkg::fifo_state_t req_state;
    glay_pkg::descriptor_t job;

    // Response path
    logic                  resp_push;
    glay_pkg::cache_resp_t resp_din;
    logic                  resp_pop;
    glay_pkg::cache_resp_t resp_head;
    glay_pkg::fifo_state_t resp_state;

    // Write path
    glay_pkg::cache_req_t  wr_req;
    logic                  wr_pending;
    logic                  wr_grant;

    // -------------------------------------------------------------------------
    // Stages
    // -------------------------------------------------------------------------
    glay_kernel_setup setup_i (
        .ap_clk      (ap_clk),
        .setup_areset(setup_areset),
        .desc_valid  (desc_valid),
        .desc        (desc),
        .req_pop     (req_pop),
        .req_head    (req_head),
        .req_state   (req_state),
        .job         (job),
        .resp_state  (resp_state),
        .done        (done)
    );

    glay_cache_arbiter arbiter_i (
        .ap_clk      (ap_clk),
        .setup_areset(setup_areset),
        .req_head    (req_head),
        .req_state   (req_state),
        .req_pop     (req_pop),
        .wr_req      (wr_req),
        .wr_pending  (wr_pending),
        .wr_grant    (wr_grant),
        .resp_state  (resp_state),
        .resp_push   (resp_push),
        .resp_din    (resp_din),
        .mem_req     (mem_req),
        .mem_valid   (mem_valid),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata)
    );

    // Read data buffer between arbiter and apply
    glay_sync_fifo #(
        .payload_t(glay_pkg::cache_resp_t)
    ) resp_fifo_i (
        .ap_clk(ap_clk),
        .srst  (setup_areset),
        .push  (resp_push),
        .din   (resp_din),
        .pop   (resp_pop),
        .dout  (resp_head),
        .state (resp_state)
    );

    glay_vertex_apply apply_i (
        .ap_clk      (ap_clk),
        .setup_areset(setup_areset),
        .job         (job),
        .resp_head   (resp_head),
        .resp_state  (resp_state),
        .resp_pop    (resp_pop),
        .wr_req      (wr_req),
        .wr_pending  (wr_pending),
        .wr_grant    (wr_grant),
        .done        (done)
    );

endmodule

//--- tests/glay_tb.sv
/*
 * Testbench for the vertex subsystem top level.
 * Models the external memory, sends random job descriptors from a fixed
 * seed and checks every read, write and done pulse against a reference
 * taken from the model memory. Build and run it through the Makefile.
 */

`include "glay_defines.svh"

module glay_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int AW         = `GLAY_ADDR_W;
    localparam int NUM_JOBS   = 6;
    localparam int DONE_LIMIT = 2000;

    logic                    ap_clk = 1'b0;
    logic                    setup_areset;
    logic                    desc_valid;
    glay_pkg::descriptor_t   desc;
    glay_pkg::cache_req_t    mem_req;
    logic                    mem_valid;
    logic                    mem_rvalid;
    logic [`GLAY_DATA_W-1:0] mem_rdata;
    logic                    done;

    // Model memory, expected results per vertex index
    logic [`GLAY_DATA_W-1:0] model_mem [2**AW];
    logic [`GLAY_DATA_W-1:0] exp_val [2**AW];
    logic                    wr_seen [2**AW];
    integer                  seed;

    // Read answer due in the next cycle
    logic                    rd_pend;
    logic [`GLAY_DATA_W-1:0] rd_pend_data;

    // Job tracking
    glay_pkg::descriptor_t   cur_job;
    logic                    job_open;
    logic [AW-1:0]           rd_count;
    logic [AW-1:0]           wr_count;
    int                      val_errors;
    int                      other_errors;

    // 4 ns period
    always #2 ap_clk = ~ap_clk;

    glay_top dut_i (
        .ap_clk      (ap_clk),
        .setup_areset(setup_areset),
        .desc_valid  (desc_valid),
        .desc        (desc),
        .mem_req     (mem_req),
        .mem_valid   (mem_valid),
        .mem_rvalid  (mem_rvalid),
        .mem_rdata   (mem_rdata),
        .done        (done)
    );

    // ------------------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------------------
    task automatic fill_memory();
        logic [AW-1:0] addr;
        addr = '0;
        repeat (2**AW) begin
            model_mem[addr] = $random(seed);
            addr = addr + 1'b1;
        end
    endtask

    // Answer last cycle's read, then take this cycle's request
    task automatic serve_memory();
        mem_rvalid = rd_pend;
        mem_rdata  = rd_pend_data;
        rd_pend    = 1'b0;
        if (mem_valid === 1'b1) begin
            if (mem_req.we) begin
                model_mem[mem_req.addr] = mem_req.wdata;
            end else begin
                rd_pend      = 1'b1;
                rd_pend_data = model_mem[mem_req.addr];
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Per-cycle checks of the memory port and done
    // ------------------------------------------------------------------------
    task automatic check_cycle();
        logic [AW-1:0] exp_addr;
        logic [AW-1:0] off;
        if (!setup_areset) begin
            assert (!$isunknown({mem_valid, done})) else begin
                other_errors++;
                $display("Unknown mem_valid or done at %0t", $time);
            end
            // Nothing moves outside an accepted job
            assert (mem_valid !== 1'b1 || job_open) else begin
                other_errors++;
                $display("Memory request at %0t with no job active", $time);
            end
            if (job_open && mem_valid === 1'b1 && !mem_req.we) begin
                exp_addr = cur_job.vertex_base + rd_count;
                assert (rd_count < cur_job.vertex_count) else begin
                    other_errors++;
                    $display("More reads than vertices at %0t", $time);
                end
                assert (mem_req.addr == exp_addr) else begin
                    val_errors++;
                    $display("Fail %0t: read address %h, expected %h",
                             $time, mem_req.addr, exp_addr);
                end
                rd_count = rd_count + 1'b1;
            end
            if (job_open && mem_valid === 1'b1 && mem_req.we) begin
                off = mem_req.addr - cur_job.result_base;
                assert (off < cur_job.vertex_count) else begin
                    val_errors++;
                    $display("Fail %0t: write to %h outside result range",
                             $time, mem_req.addr);
                end
                if (off < cur_job.vertex_count) begin
                    assert (!wr_seen[off]) else begin
                        other_errors++;
                        $display("Second write to result address %h at %0t",
                                 mem_req.addr, $time);
                    end
                    wr_seen[off] = 1'b1;
                    assert (mem_req.wdata == exp_val[off]) else begin
                        val_errors++;
                        $display("Fail %0t: result %h = %h, expected %h",
                                 $time, mem_req.addr, mem_req.wdata, exp_val[off]);
                    end
                end
                wr_count = wr_count + 1'b1;
            end
            if (done === 1'b1) begin
                assert (job_open) else begin
                    other_errors++;
                    $display("Done pulse at %0t with no job active", $time);
                end
                if (job_open) begin
                    assert (rd_count == cur_job.vertex_count) else begin
                        val_errors++;
                        $display("Fail %0t: %0d reads at done, expected %0d",
                                 $time, rd_count, cur_job.vertex_count);
                    end
                    assert (wr_count == cur_job.vertex_count) else begin
                        val_errors++;
                        $display("Fail %0t: %0d writes at done, expected %0d",
                                 $time, wr_count, cur_job.vertex_count);
                    end
                    job_open = 1'b0;
                end
            end
        end
    endtask

    // One clock, inputs change on the falling edge
    task automatic step_cycle();
        @(negedge ap_clk);
        check_cycle();
        serve_memory();
    endtask

    task automatic run_quiet(input int cycles);
        repeat (cycles) step_cycle();
    endtask

    // ------------------------------------------------------------------------
    // Descriptor stimulus
    // ------------------------------------------------------------------------
    task automatic start_job(input glay_pkg::descriptor_t next_job);
        logic [AW-1:0] k;
        k = '0;
        // Reference result is old vertex level plus one
        repeat (next_job.vertex_count) begin
            exp_val[k] = model_mem[next_job.vertex_base + k] + 1;
            k = k + 1'b1;
        end
        cur_job    = next_job;
        rd_count   = '0;
        wr_count   = '0;
        wr_seen    = '{default: 1'b0};
        job_open   = 1'b1;
        desc       = next_job;
        desc_valid = 1'b1;
        step_cycle();
        desc_valid = 1'b0;
    endtask

    // Strobe that the DUT must drop
    task automatic strobe_ignored(input glay_pkg::descriptor_t d);
        desc       = d;
        desc_valid = 1'b1;
        step_cycle();
        desc_valid = 1'b0;
    endtask

    task automatic wait_for_done(output logic ok);
        int cyc;
        cyc = 0;
        while (job_open && cyc < DONE_LIMIT) begin
            step_cycle();
            cyc++;
        end
        ok = !job_open;
        if (!ok) begin
            other_errors++;
            $display("Timeout: no done within %0d cycles for job at vertex base %h",
                     DONE_LIMIT, cur_job.vertex_base);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        glay_pkg::descriptor_t next_job;
        glay_pkg::descriptor_t stray;
        logic                  ok;
        int                    r;

        seed         = 14391;
        setup_areset = 1'b1;
        desc_valid   = 1'b0;
        desc         = '0;
        mem_rvalid   = 1'b0;
        mem_rdata    = '0;
        rd_pend      = 1'b0;
        rd_pend_data = '0;
        cur_job      = '0;
        job_open     = 1'b0;
        rd_count     = '0;
        wr_count     = '0;
        val_errors   = 0;
        other_errors = 0;
        fill_memory();

        // Reset for 3 cycles
        run_quiet(3);
        setup_areset = 1'b0;

        // Lands inside the FIFO reset-busy window
        stray.vertex_base  = 16'h4000;
        stray.result_base  = 16'hc000;
        stray.vertex_count = 16'd5;
        step_cycle();
        strobe_ignored(stray);
        run_quiet(16);

        ok = 1'b1;
        for (int j = 0; j < NUM_JOBS && ok; j++) begin
            r = $random(seed);
            next_job.vertex_base = AW'(r & 32'h3fff);
            r = $random(seed);
            next_job.result_base = AW'(32'h8000 | (r & 32'h3fff));
            r = $random(seed);
            // First job short, the rest exceed the FIFO depth
            if (j == 0) begin
                next_job.vertex_count = AW'((r & 7) + 1);
            end else begin
                next_job.vertex_count = AW'(`GLAY_FIFO_DEPTH + 1 + (r & 31));
            end
            start_job(next_job);
            // Mid-job strobe must leave no trace
            if (next_job.vertex_count > `GLAY_FIFO_DEPTH) begin
                run_quiet(4);
                strobe_ignored(stray);
            end
            wait_for_done(ok);
            if (ok) begin
                step_cycle();
            end
        end

        // Idle tail catches late traffic or a second done
        if (ok) begin
            run_quiet(20);
        end

        $display("Summary: %0d value errors, %0d other errors", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- glay_top.f
+incdir+include
hw/glay_pkg.sv
hw/glay_sync_fifo.sv
hw/glay_kernel_setup.sv
hw/glay_vertex_apply.sv
hw/glay_cache_arbiter.sv
hw/glay_top.sv
tests/glay_tb.sv

//--- Makefile
# Verilator build and run of the vertex subsystem testbench
VERILATOR ?= verilator
TOP       ?= glay_tb
FILELIST  ?= glay_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --assert --timescale $(TIMESCALE)

SIM_BIN  = $(BUILD_DIR)/V$(TOP)
SOURCES  = $(wildcard hw/*.sv) $(wildcard tests/*.sv) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
